//--- Makefile
# Verilator build and run of the execute pipeline testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= execCoreTb
FILELIST  ?= execCore.f
OBJDIR    ?= obj_dir
PASS_TEXT := TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

//--- execCore.f
+incdir+logic
logic/execCorePkg.sv
logic/aluUnit.sv
logic/instrDecode.sv
logic/executeStage.sv
logic/resultStage.sv
logic/execCore.sv
testbench/execCoreTb.sv

//--- logic/aluUnit.sv
// Combinational ALU of the execute stage
// Subtract is opB minus opA, shifts and rotates use opB[3:0] as amount
`timescale 1ns/10ps
`include "core_params.svh"

module aluUnit (
   input  execCorePkg::wordT  opA,
   input  execCorePkg::wordT  opB,
   input  execCorePkg::aluOpT aluOp,
   output execCorePkg::wordT  aluOut
);
   import execCorePkg::*;

   logic [3:0] amt;
   logic [4:0] rorFull;
   logic [3:0] rorAmt;

   // Rotate left through a doubled copy of the word
   function automatic wordT rotLeft(input wordT value, input logic [3:0] n);
      logic [2*`WORD_WIDTH-1:0] dbl;
      dbl = {value, value} << n;
      return dbl[2*`WORD_WIDTH-1:`WORD_WIDTH];
   endfunction

   assign amt = opB[3:0];

   // Right rotate by n is left rotate by 16-n, 16 wraps to 0
   assign rorFull = 5'd16 - {1'b0, amt};
   assign rorAmt  = rorFull[3:0];

   always_comb begin
      aluOut = opA;
      case (aluOp)
         `ALU_ADD:  aluOut = opA + opB;
         `ALU_SUB:  aluOut = opB - opA;
         `ALU_XOR:  aluOut = opA ^ opB;
         `ALU_ANDN: aluOut = opA & ~opB;
         `ALU_ROL:  aluOut = rotLeft(opA, amt);
         `ALU_SLL:  aluOut = opA << amt;
         `ALU_ROR:  aluOut = rotLeft(opA, rorAmt);
         `ALU_SRL:  aluOut = opA >> amt;
      endcase
   end

endmodule

//--- logic/core_params.svh
// Shared constants for the 16-bit execute pipeline
// Sizes, opcode values of instr[15:11], ALU operation codes and selector codes
// Included by the package, the RTL and the testbench reference model
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define WORD_WIDTH 16
`define REG_COUNT  8

// Opcodes in instr[15:11]
`define OP_NOP      5'b00001
`define OP_J        5'b00100
`define OP_JR       5'b00101
`define OP_ADDI     5'b01000
`define OP_SUBI     5'b01001
`define OP_XORI     5'b01010
`define OP_ANDNI    5'b01011
`define OP_BEQZ     5'b01100
`define OP_BNEZ     5'b01101
`define OP_BLTZ     5'b01110
`define OP_BGEZ     5'b01111
`define OP_SLBI     5'b10010
`define OP_ROLI     5'b10100
`define OP_SLLI     5'b10101
`define OP_RORI     5'b10110
`define OP_SRLI     5'b10111
`define OP_LBI      5'b11000
`define OP_BTR      5'b11001
`define OP_RR_SHIFT 5'b11010
`define OP_RR_ARITH 5'b11011
`define OP_SEQ      5'b11100
`define OP_SLT      5'b11101
`define OP_SLE      5'b11110
`define OP_SCO      5'b11111

// ALU operations, low two bits follow the func field
`define ALU_ADD  3'd0
`define ALU_SUB  3'd1
`define ALU_XOR  3'd2
`define ALU_ANDN 3'd3
`define ALU_ROL  3'd4
`define ALU_SLL  3'd5
`define ALU_ROR  3'd6
`define ALU_SRL  3'd7

// Result source
`define RES_ALU  2'd0
`define RES_SET  2'd1
`define RES_BTR  2'd2
`define RES_NONE 2'd3

// Branch condition and set kind both come from instr[12:11]
`define BR_ZERO    2'd0
`define BR_NONZERO 2'd1
`define BR_NEG     2'd2
`define BR_NONNEG  2'd3
`define SET_EQ     2'd0
`define SET_LT     2'd1
`define SET_LE     2'd2
`define SET_CO     2'd3

`endif

//--- logic/execCore.sv
// Top of the three-stage execute pipeline
// Instruction stream in, retire records out, both as valid/ready streams
`timescale 1ns/10ps

module execCore (
   input  logic                 clk,
   input  logic                 arstN,
   input  logic                 instrValid,
   input  execCorePkg::instrInT instrIn,
   output logic                 instrReady,
   output logic                 resValid,
   output execCorePkg::retireT  resData,
   input  logic                 resReady
);
   import execCorePkg::*;

   logic    decValid;
   logic    decReady;
   decodedT decData;
   logic    exeValid;
   logic    exeReady;
   retireT  exeData;
   regIdxT  rdAddrA;
   regIdxT  rdAddrB;
   wordT    rdDataA;
   wordT    rdDataB;
   logic    retireFire;
   regIdxT  retireReg;

   instrDecode u_instrDecode (
      .clk        (clk),
      .arstN      (arstN),
      .instrValid (instrValid),
      .instrIn    (instrIn),
      .instrReady (instrReady),
      .rdAddrA    (rdAddrA),
      .rdAddrB    (rdAddrB),
      .rdDataA    (rdDataA),
      .rdDataB    (rdDataB),
      .retireFire (retireFire),
      .retireReg  (retireReg),
      .decValid   (decValid),
      .decData    (decData),
      .decReady   (decReady)
   );

   executeStage u_executeStage (
      .clk      (clk),
      .arstN    (arstN),
      .decValid (decValid),
      .decData  (decData),
      .decReady (decReady),
      .exeValid (exeValid),
      .exeData  (exeData),
      .exeReady (exeReady)
   );

   // Also owns the register file read by decode
   resultStage u_resultStage (
      .clk        (clk),
      .arstN      (arstN),
      .exeValid   (exeValid),
      .exeData    (exeData),
      .exeReady   (exeReady),
      .resValid   (resValid),
      .resData    (resData),
      .resReady   (resReady),
      .rdAddrA    (rdAddrA),
      .rdAddrB    (rdAddrB),
      .rdDataA    (rdDataA),
      .rdDataB    (rdDataB),
      .retireFire (retireFire),
      .retireReg  (retireReg)
   );

endmodule

//--- logic/execCorePkg.sv
// Types shared by the execute pipeline stages
// Stage records travel between stages as packed structs
`include "core_params.svh"

package execCorePkg;

   typedef logic [`WORD_WIDTH-1:0] wordT;
   typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;
   typedef logic [2:0] aluOpT;
   typedef logic [1:0] resKindT;
   typedef logic [1:0] brCondT;
   typedef logic [1:0] setKindT;

   // Fetched instruction entering decode
   typedef struct packed {
      wordT instr;
      wordT pc;
   } instrInT;

   // Decoded record between decode and execute
   typedef struct packed {
      wordT    pc;
      wordT    opA;
      wordT    opB;
      wordT    offset;
      aluOpT   aluOp;
      resKindT resKind;
      setKindT setKind;
      brCondT  brCond;
      logic    isBranch;
      logic    isJump;
      logic    jumpViaReg;
      logic    isLbi;
      logic    isSlbi;
      logic    wrEn;
      regIdxT  wrReg;
   } decodedT;

   // Retire record, also the output stream payload
   typedef struct packed {
      wordT   pc;
      wordT   nextPc;
      logic   wrEn;
      regIdxT wrReg;
      wordT   wrData;
   } retireT;

endpackage

//--- logic/executeStage.sv
// Execute stage: ALU operand shaping, set/compare, bit reverse, next PC
// Produces the retire record and holds it for the result stage
`timescale 1ns/10ps
`include "core_params.svh"

module executeStage (
   input  logic                 clk,
   input  logic                 arstN,
   input  logic                 decValid,
   input  execCorePkg::decodedT decData,
   output logic                 decReady,
   output logic                 exeValid,
   output execCorePkg::retireT  exeData,
   input  logic                 exeReady
);
   import execCorePkg::*;

   wordT aluA;
   wordT aluOut;
   wordT revA;
   wordT pcPlus2;
   wordT target;
   logic [`WORD_WIDTH:0] carrySum;
   logic isEq;
   logic isLt;
   logic setBit;
   logic condMet;
   logic taken;
   retireT eNext;

   // SLBI moves Rs up a byte, LBI lets the immediate through alone
   assign aluA = decData.isSlbi ? (decData.opA << 8) :
                 decData.isLbi  ? '0 : decData.opA;

   aluUnit u_aluUnit (
      .opA    (aluA),
      .opB    (decData.opB),
      .aluOp  (decData.aluOp),
      .aluOut (aluOut)
   );

   // Set and compare on Rs, Rt
   assign carrySum = {1'b0, decData.opA} + {1'b0, decData.opB};
   assign isEq     = decData.opA == decData.opB;
   assign isLt     = $signed(decData.opA) < $signed(decData.opB);

   always_comb begin
      case (decData.setKind)
         `SET_EQ: setBit = isEq;
         `SET_LT: setBit = isLt;
         `SET_LE: setBit = isLt || isEq;
         `SET_CO: setBit = carrySum[`WORD_WIDTH];
      endcase
   end

   always_comb begin
      for (int i = 0; i < `WORD_WIDTH; i++) begin
         revA[i] = decData.opA[`WORD_WIDTH-1-i];
      end
   end

   // Branch condition tested on Rs
   always_comb begin
      case (decData.brCond)
         `BR_ZERO:    condMet = decData.opA == '0;
         `BR_NONZERO: condMet = decData.opA != '0;
         `BR_NEG:     condMet = decData.opA[`WORD_WIDTH-1];
         `BR_NONNEG:  condMet = !decData.opA[`WORD_WIDTH-1];
      endcase
   end

   assign pcPlus2 = decData.pc + wordT'(2);
   assign target  = (decData.jumpViaReg ? decData.opA : pcPlus2) + decData.offset;
   assign taken   = decData.isJump || (decData.isBranch && condMet);

   always_comb begin
      eNext.pc     = decData.pc;
      eNext.nextPc = taken ? target : pcPlus2;
      eNext.wrEn   = decData.wrEn;
      eNext.wrReg  = decData.wrReg;
      case (decData.resKind)
         `RES_ALU:  eNext.wrData = aluOut;
         `RES_SET:  eNext.wrData = {{(`WORD_WIDTH-1){1'b0}}, setBit};
         `RES_BTR:  eNext.wrData = revA;
         `RES_NONE: eNext.wrData = '0;
      endcase
   end

   assign decReady = !exeValid || exeReady;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         exeValid <= 1'b0;
      end else if (decReady) begin
         exeValid <= decValid;
      end
   end

   always_ff @(posedge clk) begin
      if (decValid && decReady) begin
         exeData <= eNext;
      end
   end

endmodule

//--- logic/instrDecode.sv
// Decode stage: opcode decode, operand read, immediate extension
// Holds back instructions touching a register still owned by an older writer
`timescale 1ns/10ps
`include "core_params.svh"

module instrDecode (
   input  logic                 clk,
   input  logic                 arstN,
   input  logic                 instrValid,
   input  execCorePkg::instrInT instrIn,
   output logic                 instrReady,
   output execCorePkg::regIdxT  rdAddrA,
   output execCorePkg::regIdxT  rdAddrB,
   input  execCorePkg::wordT    rdDataA,
   input  execCorePkg::wordT    rdDataB,
   input  logic                 retireFire,
   input  execCorePkg::regIdxT  retireReg,
   output logic                 decValid,
   output execCorePkg::decodedT decData,
   input  logic                 decReady
);
   import execCorePkg::*;

   logic [4:0] opcode;
   regIdxT rs;
   regIdxT rt;
   regIdxT rdR;
   regIdxT rdI;
   wordT immSext5;
   wordT immZext5;
   wordT immSext8;
   wordT immZext8;
   wordT dispSext11;
   wordT immVal;
   logic usesA;
   logic usesB;
   logic hazard;
   logic accept;
   decodedT dNext;
   logic [`REG_COUNT-1:0] busy;
   logic [`REG_COUNT-1:0] pendMask;
   logic [`REG_COUNT-1:0] busyView;
   logic [`REG_COUNT-1:0] setMask;
   logic [`REG_COUNT-1:0] clrMask;

   assign opcode = instrIn.instr[15:11];
   assign rs     = instrIn.instr[10:8];
   assign rt     = instrIn.instr[7:5];
   assign rdR    = instrIn.instr[4:2];
   assign rdI    = instrIn.instr[7:5];

   assign immSext5   = {{(`WORD_WIDTH-5){instrIn.instr[4]}}, instrIn.instr[4:0]};
   assign immZext5   = {{(`WORD_WIDTH-5){1'b0}}, instrIn.instr[4:0]};
   assign immSext8   = {{(`WORD_WIDTH-8){instrIn.instr[7]}}, instrIn.instr[7:0]};
   assign immZext8   = {{(`WORD_WIDTH-8){1'b0}}, instrIn.instr[7:0]};
   assign dispSext11 = {{(`WORD_WIDTH-11){instrIn.instr[10]}}, instrIn.instr[10:0]};

   assign rdAddrA = rs;
   assign rdAddrB = rt;

   always_comb begin
      dNext         = '0;
      dNext.pc      = instrIn.pc;
      dNext.opA     = rdDataA;
      dNext.resKind = `RES_NONE;
      // Encodings chosen so instr[12:11] is the condition or compare kind
      dNext.setKind = instrIn.instr[12:11];
      dNext.brCond  = instrIn.instr[12:11];
      usesA         = 1'b0;
      usesB         = 1'b0;
      immVal        = immZext5;
      case (opcode)
         `OP_ADDI, `OP_SUBI: begin
            usesA         = 1'b1;
            immVal        = immSext5;
            dNext.aluOp   = {1'b0, opcode[1:0]};
            dNext.resKind = `RES_ALU;
            dNext.wrEn    = 1'b1;
            dNext.wrReg   = rdI;
         end
         `OP_XORI, `OP_ANDNI: begin
            usesA         = 1'b1;
            dNext.aluOp   = {1'b0, opcode[1:0]};
            dNext.resKind = `RES_ALU;
            dNext.wrEn    = 1'b1;
            dNext.wrReg   = rdI;
         end
         `OP_ROLI, `OP_SLLI, `OP_RORI, `OP_SRLI: begin
            usesA         = 1'b1;
            dNext.aluOp   = {1'b1, opcode[1:0]};
            dNext.resKind = `RES_ALU;
            dNext.wrEn    = 1'b1;
            dNext.wrReg   = rdI;
         end
         `OP_RR_ARITH, `OP_RR_SHIFT: begin
            usesA         = 1'b1;
            usesB         = 1'b1;
            // func field picks the operation within the group
            dNext.aluOp   = {opcode == `OP_RR_SHIFT, instrIn.instr[1:0]};
            dNext.resKind = `RES_ALU;
            dNext.wrEn    = 1'b1;
            dNext.wrReg   = rdR;
         end
         `OP_SEQ, `OP_SLT, `OP_SLE, `OP_SCO: begin
            usesA         = 1'b1;
            usesB         = 1'b1;
            dNext.resKind = `RES_SET;
            dNext.wrEn    = 1'b1;
            dNext.wrReg   = rdR;
         end
         `OP_BTR: begin
            usesA         = 1'b1;
            dNext.resKind = `RES_BTR;
            dNext.wrEn    = 1'b1;
            dNext.wrReg   = rdR;
         end
         `OP_LBI: begin
            immVal        = immSext8;
            dNext.isLbi   = 1'b1;
            dNext.aluOp   = `ALU_ADD;
            dNext.resKind = `RES_ALU;
            dNext.wrEn    = 1'b1;
            dNext.wrReg   = rs;
         end
         `OP_SLBI: begin
            // Low byte of Rs<<8 is zero, so xor acts as or
            usesA         = 1'b1;
            immVal        = immZext8;
            dNext.isSlbi  = 1'b1;
            dNext.aluOp   = `ALU_XOR;
            dNext.resKind = `RES_ALU;
            dNext.wrEn    = 1'b1;
            dNext.wrReg   = rs;
         end
         `OP_BEQZ, `OP_BNEZ, `OP_BLTZ, `OP_BGEZ: begin
            usesA          = 1'b1;
            dNext.isBranch = 1'b1;
            dNext.offset   = immSext8;
         end
         `OP_J: begin
            dNext.isJump = 1'b1;
            dNext.offset = dispSext11;
         end
         `OP_JR: begin
            usesA            = 1'b1;
            dNext.isJump     = 1'b1;
            dNext.jumpViaReg = 1'b1;
            dNext.offset     = immSext8;
         end
         default: begin
            // NOP and unknown opcodes retire without a write
            dNext.resKind = `RES_NONE;
         end
      endcase
      dNext.opB = usesB ? rdDataB : immVal;
   end

   // Writer waiting in the decode register is not yet marked busy
   assign pendMask = (decValid && decData.wrEn) ?
                     ({{(`REG_COUNT-1){1'b0}}, 1'b1} << decData.wrReg) : '0;
   assign busyView = busy | pendMask;

   assign hazard = (usesA && busyView[rs]) || (usesB && busyView[rt]) ||
                   (dNext.wrEn && busyView[dNext.wrReg]);

   assign instrReady = (!decValid || decReady) && !hazard;
   assign accept     = instrValid && instrReady;

   assign setMask = (decValid && decReady && decData.wrEn) ?
                    ({{(`REG_COUNT-1){1'b0}}, 1'b1} << decData.wrReg) : '0;
   assign clrMask = retireFire ? ({{(`REG_COUNT-1){1'b0}}, 1'b1} << retireReg) : '0;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         busy <= '0;
      end else begin
         busy <= (busy & ~clrMask) | setMask;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         decValid <= 1'b0;
      end else if (!decValid || decReady) begin
         decValid <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         decData <= dNext;
      end
   end

endmodule

//--- logic/resultStage.sv
// Result stage: retire register, architectural register file, output handshake
// The register file is written when a record leaves on the output stream
`timescale 1ns/10ps
`include "core_params.svh"

module resultStage (
   input  logic                clk,
   input  logic                arstN,
   input  logic                exeValid,
   input  execCorePkg::retireT exeData,
   output logic                exeReady,
   output logic                resValid,
   output execCorePkg::retireT resData,
   input  logic                resReady,
   input  execCorePkg::regIdxT rdAddrA,
   input  execCorePkg::regIdxT rdAddrB,
   output execCorePkg::wordT   rdDataA,
   output execCorePkg::wordT   rdDataB,
   output logic                retireFire,
   output execCorePkg::regIdxT retireReg
);
   import execCorePkg::*;

   wordT regFile [`REG_COUNT];
   logic outFire;

   assign outFire  = resValid && resReady;
   assign exeReady = !resValid || resReady;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         resValid <= 1'b0;
      end else if (exeReady) begin
         resValid <= exeValid;
      end
   end

   always_ff @(posedge clk) begin
      if (exeValid && exeReady) begin
         resData <= exeData;
      end
   end

   // Architectural state, cleared at reset
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         regFile <= '{default: '0};
      end else if (retireFire) begin
         regFile[resData.wrReg] <= resData.wrData;
      end
   end

   // Decode reads after the write edge, scoreboard keeps readers waiting
   assign rdDataA = regFile[rdAddrA];
   assign rdDataB = regFile[rdAddrB];

   assign retireFire = outFire && resData.wrEn;
   assign retireReg  = resData.wrReg;

endmodule

//--- testbench/execCoreTb.sv
// Testbench of the execute pipeline
// Drives a random instruction stream against a reference register model
// with random output back-pressure and checks every retired record
// Run through the Makefile test target
`timescale 1ns/10ps
`include "core_params.svh"

module execCoreTb;
   import execCorePkg::*;

   localparam int NUM_INSTR   = 400;
   localparam int CYCLE_LIMIT = NUM_INSTR * 12 + 200;

   logic    clk = 1'b0;
   logic    arstN;
   logic    instrValid;
   instrInT instrIn;
   logic    instrReady;
   logic    resValid;
   retireT  resData;
   logic    resReady;

   integer  seed;
   int      cycleCount = 0;
   int      acceptCount = 0;
   int      retiredCount = 0;
   logic    seenAccept = 1'b0;
   logic    holdPending = 1'b0;
   retireT  heldRecord;
   regIdxT  pairReg;
   wordT    refRegs [`REG_COUNT];
   retireT  expQ [$];

   execCore u_execCore (
      .clk        (clk),
      .arstN      (arstN),
      .instrValid (instrValid),
      .instrIn    (instrIn),
      .instrReady (instrReady),
      .resValid   (resValid),
      .resData    (resData),
      .resReady   (resReady)
   );

   always #2 clk = ~clk;

   task automatic failWith(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic reportMismatch(input string name, input wordT expV, input wordT gotV);
      failWith($sformatf("ERROR %s expected 0x%h actual 0x%h", name, expV, gotV));
   endtask

   function automatic wordT rotateLeft(input wordT x, input logic [3:0] n);
      logic [4:0] inv;
      inv = 5'd16 - {1'b0, n};
      return (x << n) | (x >> inv);
   endfunction

   function automatic wordT rotateRight(input wordT x, input logic [3:0] n);
      logic [4:0] inv;
      inv = 5'd16 - {1'b0, n};
      return (x >> n) | (x << inv);
   endfunction

   // In R format the func field picks the operation and subtract is Rt minus Rs
   function automatic wordT regRegResult(input logic isShift, input logic [1:0] fn,
                                         input wordT a, input wordT b);
      if (!isShift) begin
         case (fn)
            2'd0: return a + b;
            2'd1: return b - a;
            2'd2: return a ^ b;
            default: return a & ~b;
         endcase
      end
      case (fn)
         2'd0: return rotateLeft(a, b[3:0]);
         2'd1: return a << b[3:0];
         2'd2: return rotateRight(a, b[3:0]);
         default: return a >> b[3:0];
      endcase
   endfunction

   // Only ADDI and SUBI sign-extend their 5-bit immediate
   function automatic wordT immResult(input logic [4:0] op, input wordT a, input logic [4:0] imm);
      wordT s;
      wordT z;
      s = wordT'($signed(imm));
      z = wordT'(imm);
      case (op)
         `OP_ADDI:  return a + s;
         `OP_SUBI:  return s - a;
         `OP_XORI:  return a ^ z;
         `OP_ANDNI: return a & ~z;
         `OP_ROLI:  return rotateLeft(a, z[3:0]);
         `OP_SLLI:  return a << z[3:0];
         `OP_RORI:  return rotateRight(a, z[3:0]);
         default:   return a >> z[3:0];
      endcase
   endfunction

   // Expected retire record from the architectural model at acceptance
   function automatic retireT predict(input wordT instr, input wordT pc);
      retireT r;
      logic [4:0] op;
      wordT a;
      wordT b;
      wordT imm8s;
      logic [`WORD_WIDTH:0] sum;
      op = instr[15:11];
      a = refRegs[instr[10:8]];
      b = refRegs[instr[7:5]];
      imm8s = wordT'($signed(instr[7:0]));
      sum = {1'b0, a} + {1'b0, b};
      r = '0;
      r.pc = pc;
      r.nextPc = pc + 16'd2;
      r.wrEn = 1'b1;
      r.wrReg = instr[4:2];
      case (op)
         `OP_RR_ARITH, `OP_RR_SHIFT:
            r.wrData = regRegResult(op == `OP_RR_SHIFT, instr[1:0], a, b);
         `OP_ADDI, `OP_SUBI, `OP_XORI, `OP_ANDNI,
         `OP_ROLI, `OP_SLLI, `OP_RORI, `OP_SRLI: begin
            r.wrReg = instr[7:5];
            r.wrData = immResult(op, a, instr[4:0]);
         end
         `OP_SEQ: r.wrData = wordT'(a == b);
         `OP_SLT: r.wrData = wordT'($signed(a) < $signed(b));
         `OP_SLE: r.wrData = wordT'($signed(a) <= $signed(b));
         `OP_SCO: r.wrData = wordT'(sum[`WORD_WIDTH]);
         `OP_BTR: r.wrData = {<<{a}};
         `OP_LBI: begin
            r.wrReg = instr[10:8];
            r.wrData = imm8s;
         end
         `OP_SLBI: begin
            r.wrReg = instr[10:8];
            r.wrData = (a << 8) | wordT'(instr[7:0]);
         end
         `OP_BEQZ, `OP_BNEZ, `OP_BLTZ, `OP_BGEZ: begin
            r.wrEn = 1'b0;
            if ((op == `OP_BEQZ && a == '0) || (op == `OP_BNEZ && a != '0) ||
                (op == `OP_BLTZ && a[15]) || (op == `OP_BGEZ && !a[15])) begin
               r.nextPc = pc + 16'd2 + imm8s;
            end
         end
         `OP_J: begin
            r.wrEn = 1'b0;
            r.nextPc = pc + 16'd2 + wordT'($signed(instr[10:0]));
         end
         `OP_JR: begin
            r.wrEn = 1'b0;
            r.nextPc = a + imm8s;
         end
         default: r.wrEn = 1'b0;
      endcase
      return r;
   endfunction

   function automatic logic [4:0] pickOp(input logic [1:0] sel,
                                         input logic [4:0] op0, input logic [4:0] op1,
                                         input logic [4:0] op2, input logic [4:0] op3);
      case (sel)
         2'd0: return op0;
         2'd1: return op1;
         2'd2: return op2;
         default: return op3;
      endcase
   endfunction

   // Random instruction where the first eight load registers with LBI/SLBI pairs
   task automatic makeInstr(input int index, output wordT instr);
      logic [31:0] rnd;
      rnd = $random(seed);
      if (index < 8) begin
         if (index % 2 == 0) begin
            pairReg = rnd[13:11];
            instr = {`OP_LBI, pairReg, rnd[7:0]};
         end else begin
            instr = {`OP_SLBI, pairReg, rnd[7:0]};
         end
      end else begin
         case (rnd[31:28])
            4'd0, 4'd13: instr = {`OP_RR_ARITH, rnd[2:0], rnd[5:3], rnd[8:6], rnd[10:9]};
            4'd1: instr = {`OP_RR_SHIFT, rnd[2:0], rnd[5:3], rnd[8:6], rnd[10:9]};
            4'd2, 4'd14: instr = {pickOp(rnd[12:11], `OP_ADDI, `OP_SUBI, `OP_XORI, `OP_ANDNI),
                                  rnd[2:0], rnd[5:3], rnd[10:6]};
            4'd3: instr = {pickOp(rnd[12:11], `OP_ROLI, `OP_SLLI, `OP_RORI, `OP_SRLI),
                           rnd[2:0], rnd[5:3], rnd[10:6]};
            4'd4: instr = {`OP_LBI, rnd[2:0], rnd[10:3]};
            4'd5: instr = {`OP_SLBI, rnd[2:0], rnd[10:3]};
            4'd6: instr = {`OP_BTR, rnd[2:0], 3'b000, rnd[5:3], 2'b00};
            4'd7, 4'd8, 4'd15: instr = {pickOp(rnd[12:11], `OP_SEQ, `OP_SLT, `OP_SLE, `OP_SCO),
                                        rnd[2:0], rnd[5:3], rnd[8:6], 2'b00};
            4'd9: instr = {pickOp(rnd[12:11], `OP_BEQZ, `OP_BNEZ, `OP_BLTZ, `OP_BGEZ),
                           rnd[2:0], rnd[10:3]};
            4'd10: instr = {`OP_J, rnd[10:0]};
            4'd11: instr = {`OP_JR, rnd[2:0], rnd[10:3]};
            // NOP and opcodes outside the supported set
            default: instr = {pickOp(rnd[12:11], `OP_NOP, 5'b00000, 5'b00010, 5'b10000),
                              rnd[10:0]};
         endcase
      end
   endtask

   // Handshakes are stable mid-cycle and transfer at the next rising edge
   always @(negedge clk) begin
      retireT want;
      cycleCount++;
      if (cycleCount >= CYCLE_LIMIT) begin
         failWith($sformatf("Timeout after %0d cycles with %0d of %0d instructions retired",
                            cycleCount, retiredCount, NUM_INSTR));
      end
      if (!seenAccept) begin
         assert (!resValid)
            else failWith("resValid went high before any instruction was accepted");
         assert (instrReady) else failWith("instrReady was low before the first instruction");
      end
      if (holdPending) begin
         assert (resValid) else failWith("resValid dropped before its record was taken");
         assert (resData == heldRecord) else failWith("resData changed while resReady was low");
      end
      if (resValid && resReady) begin
         assert (expQ.size() > 0)
            else failWith("Output record with no instruction outstanding");
         want = expQ.pop_front();
         assert (resData.pc == want.pc) else reportMismatch("resData.pc", want.pc, resData.pc);
         assert (resData.nextPc == want.nextPc)
            else reportMismatch("resData.nextPc", want.nextPc, resData.nextPc);
         assert (resData.wrEn == want.wrEn)
            else reportMismatch("resData.wrEn", wordT'(want.wrEn), wordT'(resData.wrEn));
         if (want.wrEn) begin
            assert (resData.wrReg == want.wrReg)
               else reportMismatch("resData.wrReg", wordT'(want.wrReg), wordT'(resData.wrReg));
            assert (resData.wrData == want.wrData)
               else reportMismatch("resData.wrData", want.wrData, resData.wrData);
         end
         retiredCount++;
      end
      if (arstN && instrValid && instrReady) begin
         want = predict(instrIn.instr, instrIn.pc);
         if (want.wrEn) begin
            refRegs[want.wrReg] = want.wrData;
         end
         expQ.push_back(want);
         acceptCount++;
         seenAccept = 1'b1;
      end
      holdPending = resValid && !resReady;
      heldRecord = resData;
   end

   initial begin
      wordT instrWord;
      wordT pcCounter;
      logic [31:0] rnd;
      int offered;
      int driveCycle;
      seed = 32'h8e72_d189;
      arstN = 1'b0;
      instrValid = 1'b0;
      instrIn = '0;
      resReady = 1'b0;
      foreach (refRegs[i]) begin
         refRegs[i] = '0;
      end
      // PC stream starts near the top so pc+2 wraps during the run
      pcCounter = 16'hff00;
      offered = 0;
      driveCycle = 0;
      repeat (16) @(posedge clk);
      #0.5;
      arstN = 1'b1;
      while (retiredCount < NUM_INSTR) begin
         if (acceptCount == offered && offered < NUM_INSTR) begin
            makeInstr(offered, instrWord);
            instrIn.instr = instrWord;
            instrIn.pc = pcCounter;
            pcCounter = pcCounter + 16'd2;
            instrValid = 1'b1;
            offered++;
         end else if (acceptCount == offered) begin
            instrValid = 1'b0;
         end
         // Two long stalls fill the pipeline and the rest runs at about half duty
         if ((driveCycle >= 150 && driveCycle < 180) || (driveCycle >= 600 && driveCycle < 630)) begin
            resReady = 1'b0;
         end else begin
            rnd = $random(seed);
            resReady = rnd[0];
         end
         @(posedge clk);
         #0.5;
         driveCycle++;
      end
      instrValid = 1'b0;
      resReady = 1'b1;
      repeat (8) @(negedge clk);
      // Drained pipeline holds no record and the scoreboard lets the last instruction in
      if (!resValid && instrReady) begin
         $display("TEST PASSED");
         $finish;
      end else begin
         failWith("Pipeline did not return to idle after the last instruction retired");
      end
   end

endmodule
